/* tb.f */
udma_pkg.sv
udma_ch_addrgen.sv
udma_ch_regs.sv
udma_ch_arbiter.sv
udma_l2_req.sv
udma_subsys.sv
tb_udma_subsys.sv

/* tb_udma_subsys.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_udma_subsys;

	// Total test traffic stays well below 1000 cycles.
	localparam int MAX_CYCLES = 4000;
	localparam int IDLE_LIMIT = 600;

	logic                 clk_i;
	logic                 rstn_i;
	logic                 reg_valid_i;
	logic                 reg_we_i;
	logic [0:0]           reg_ch_i;
	udma_pkg::reg_off_t   reg_off_i;
	udma_pkg::reg_data_t  reg_wdata_i;
	udma_pkg::reg_data_t  reg_rdata_o;
	logic                 l2_ready_i;
	logic                 l2_req_o;
	udma_pkg::l2_addr_t   l2_addr_o;
	logic [3:0]           l2_be_o;
	logic                 l2_we_o;
	udma_pkg::stream_t    l2_stream_o;
	udma_pkg::stream_id_t l2_stream_id_o;
	logic [1:0]           ch_event_o;
	logic [1:0]           ch_sot_o;
	logic [1:0]           ch_active_o;

	integer seed = 32'hbd7f375d;
	int     errors = 0;
	int     err_mark = 0;
	int     tests = 0;
	int     failed = 0;
	int     cycles = 0;
	bit     rand_ready = 0;
	bit     ready_low = 0;
	bit     alt_chk = 0;
	int     req_cnt [2];
	int     ev_cnt [2];
	int     sot_cnt [2];
	int     pass_cnt [2];

	// Expected beat state per channel.
	udma_pkg::l2_addr_t m_addr [2];
	udma_pkg::l2_addr_t m_start [2];
	int                 m_left [2];
	int                 m_size [2];
	int                 m_beat [2];
	bit                 prev_req;
	int                 prev_ch;
	logic [1:0]         act_q1;
	logic [1:0]         act_q2;

	udma_subsys #(
		.N_CH (2)
	) u_udma_subsys (
		.clk_i          (clk_i),
		.rstn_i         (rstn_i),
		.reg_valid_i    (reg_valid_i),
		.reg_we_i       (reg_we_i),
		.reg_ch_i       (reg_ch_i),
		.reg_off_i      (reg_off_i),
		.reg_wdata_i    (reg_wdata_i),
		.reg_rdata_o    (reg_rdata_o),
		.l2_ready_i     (l2_ready_i),
		.l2_req_o       (l2_req_o),
		.l2_addr_o      (l2_addr_o),
		.l2_be_o        (l2_be_o),
		.l2_we_o        (l2_we_o),
		.l2_stream_o    (l2_stream_o),
		.l2_stream_id_o (l2_stream_id_o),
		.ch_event_o     (ch_event_o),
		.ch_sot_o       (ch_sot_o),
		.ch_active_o    (ch_active_o)
	);

	initial begin : clock_gen
		clk_i = 1'b0;
		forever begin
			#2 clk_i = ~clk_i;
		end
	end

	initial begin : watchdog
		while (cycles < MAX_CYCLES) begin
			@(posedge clk_i);
			cycles++;
		end
		$display("Timeout after %0d cycles, the run did not complete", cycles);
		$display("Something failed");
		$finish;
	end

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			errors++;
			$display("Fail %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic flag_error(input string msg);
		errors++;
		$display("Error: %s", msg);
	endtask

	function automatic logic [31:0] cfg_word(input bit cont, input int ds, input bit en,
			input bit clr, input int ch);
		logic [31:0] w;
		w = '0;
		w[0] = cont;
		w[2:1] = 2'(ds);
		w[4] = en;
		w[5] = clr;
		w[7:6] = (ch == 0) ? 2'd1 : 2'd3;
		w[10:8] = (ch == 0) ? 3'd5 : 3'd2;
		return w;
	endfunction

	task automatic write_reg(input int ch, input logic [1:0] off, input logic [31:0] data);
		@(negedge clk_i);
		reg_valid_i = 1'b1;
		reg_we_i = 1'b1;
		reg_ch_i = 1'(ch);
		reg_off_i = off;
		reg_wdata_i = data;
		@(negedge clk_i);
		reg_valid_i = 1'b0;
		reg_we_i = 1'b0;
	endtask

	task automatic read_reg(input int ch, input logic [1:0] off, output logic [31:0] data);
		@(negedge clk_i);
		reg_valid_i = 1'b1;
		reg_we_i = 1'b0;
		reg_ch_i = 1'(ch);
		reg_off_i = off;
		@(negedge clk_i);
		reg_valid_i = 1'b0;
		data = reg_rdata_o;
	endtask

	task automatic setup_ch(input int ch, input udma_pkg::l2_addr_t start, input int size,
			input int ds);
		m_start[ch] = start;
		m_addr[ch] = start;
		m_size[ch] = size;
		m_left[ch] = size;
		m_beat[ch] = 1 << ds;
		write_reg(ch, udma_pkg::REG_SADDR, 32'(start));
		write_reg(ch, udma_pkg::REG_SIZE, 32'(size));
	endtask

	task automatic wait_reqs(input int ch, input int n_req, input bit need_idle);
		int n;
		n = 0;
		while ((req_cnt[ch] < n_req || (need_idle && ch_active_o[ch])) && n < IDLE_LIMIT) begin
			@(posedge clk_i);
			n++;
		end
		if (n >= IDLE_LIMIT) begin
			flag_error($sformatf("channel %0d did not reach %0d requests", ch, n_req));
		end
		repeat (3) @(negedge clk_i);
	endtask

	task automatic clear_counts();
		@(posedge clk_i);
		for (int c = 0; c < 2; c++) begin
			req_cnt[c] = 0;
			ev_cnt[c] = 0;
			sot_cnt[c] = 0;
			pass_cnt[c] = 0;
		end
	endtask

	task automatic finish_test(input string name);
		tests++;
		if (errors != err_mark) begin
			failed++;
			$display("test %0d %s: %0d errors", tests, name, errors - err_mark);
		end else begin
			$display("test %0d %s: passed", tests, name);
		end
		err_mark = errors;
	endtask

	always @(negedge clk_i) begin : ready_drive
		if (ready_low) begin
			l2_ready_i <= 1'b0;
		end else if (rand_ready) begin
			l2_ready_i <= 1'($random(seed));
		end else begin
			l2_ready_i <= 1'b1;
		end
	end

	// Checks each request against the expected beat of its channel.
	always @(negedge clk_i) begin : monitor
		int c;
		int nb;
		logic [3:0] be;
		c = (l2_stream_id_o == 3'd5) ? 0 : 1;
		if (rstn_i && l2_req_o) begin
			if (l2_stream_id_o != 3'd5 && l2_stream_id_o != 3'd2) begin
				flag_error("request carries a stream id of no channel");
			end else begin
				nb = (m_left[c] <= m_beat[c]) ? m_left[c] : m_beat[c];
				be = 4'(((1 << nb) - 1) << m_addr[c][1:0]);
				check_val("l2_addr_o", {m_addr[c][17:2], 2'b00}, l2_addr_o);
				check_val("l2_be_o", be, l2_be_o);
				check_val("l2_we_o", (c == 0), l2_we_o);
				check_val("l2_stream_o", (c == 0) ? 1 : 3, l2_stream_o);
				if (alt_chk && prev_req && act_q1 == 2'b11 && act_q2 == 2'b11) begin
					assert (c != prev_ch) else flag_error("two active channels did not alternate");
				end
				if (m_left[c] > m_beat[c]) begin
					m_addr[c] = m_addr[c] + 18'(m_beat[c]);
					m_left[c] = m_left[c] - m_beat[c];
				end else begin
					m_addr[c] = m_start[c];
					m_left[c] = m_size[c];
					pass_cnt[c]++;
				end
				req_cnt[c]++;
			end
		end
		for (int i = 0; i < 2; i++) begin
			ev_cnt[i] += ch_event_o[i];
			sot_cnt[i] += ch_sot_o[i];
		end
		prev_req = l2_req_o;
		prev_ch = c;
		act_q2 = act_q1;
		act_q1 = ch_active_o;
	end

	a_no_req_after_stall: assert property (
		@(posedge clk_i) disable iff (!rstn_i) !l2_ready_i |=> !l2_req_o
	) else flag_error("request issued in the cycle after L2 was not ready");

	a_req_from_active: assert property (
		@(posedge clk_i) disable iff (!rstn_i) l2_req_o |-> $past(|ch_active_o)
	) else flag_error("request issued with no active channel");

	initial begin : main
		logic [31:0] rd;
		rstn_i = 1'b0;
		reg_valid_i = 1'b0;
		reg_we_i = 1'b0;
		reg_ch_i = '0;
		reg_off_i = '0;
		reg_wdata_i = '0;
		l2_ready_i = 1'b1;
		repeat (8) @(posedge clk_i);
		@(negedge clk_i);
		rstn_i = 1'b1;

		check_val("l2_req_o", 0, l2_req_o);
		check_val("ch_active_o", 0, ch_active_o);
		check_val("ch_event_o", 0, ch_event_o);
		check_val("ch_sot_o", 0, ch_sot_o);
		write_reg(0, udma_pkg::REG_SADDR, 32'h0001_2345);
		write_reg(0, udma_pkg::REG_SIZE, 32'h0000_00a5);
		write_reg(0, udma_pkg::REG_CFG, cfg_word(1, 2, 0, 0, 0));
		read_reg(0, udma_pkg::REG_SADDR, rd);
		check_val("SADDR", 32'h0001_2345, rd);
		read_reg(0, udma_pkg::REG_SIZE, rd);
		check_val("SIZE", 32'h0000_00a5, rd);
		read_reg(0, udma_pkg::REG_CFG, rd);
		check_val("CFG", cfg_word(1, 2, 0, 0, 0), rd);
		read_reg(0, udma_pkg::REG_STATUS, rd);
		check_val("STATUS", 0, rd);
		finish_test("register readback");

		clear_counts();
		setup_ch(0, 18'h00101, 5, 0);
		write_reg(0, udma_pkg::REG_CFG, cfg_word(0, 0, 1, 0, 0));
		wait_reqs(0, 5, 1);
		check_val("requests ch0", 5, req_cnt[0]);
		check_val("ch_event_o[0] pulses", 1, ev_cnt[0]);
		finish_test("byte transfer ch0");

		clear_counts();
		setup_ch(1, 18'h00200, 10, 2);
		write_reg(1, udma_pkg::REG_CFG, cfg_word(0, 2, 1, 0, 1));
		wait_reqs(1, 3, 1);
		check_val("requests ch1", 3, req_cnt[1]);
		check_val("ch_event_o[1] pulses", 1, ev_cnt[1]);
		finish_test("word transfer ch1");

		clear_counts();
		setup_ch(0, 18'h00400, 8, 2);
		write_reg(0, udma_pkg::REG_CFG, cfg_word(1, 2, 1, 0, 0));
		wait_reqs(0, 6, 0);
		// L2 held off so the clear lands between beats.
		ready_low = 1'b1;
		write_reg(0, udma_pkg::REG_CFG, cfg_word(0, 2, 0, 1, 0));
		wait_reqs(0, 6, 1);
		ready_low = 1'b0;
		assert (ev_cnt[0] >= 2) else flag_error("continuous mode ended fewer than two passes");
		check_val("ch_event_o[0] pulses", pass_cnt[0], ev_cnt[0]);
		check_val("ch_sot_o[0] pulses", pass_cnt[0] + 1, sot_cnt[0]);
		finish_test("continuous mode");

		clear_counts();
		alt_chk = 1'b1;
		setup_ch(0, 18'h00800, 12, 0);
		setup_ch(1, 18'h00c02, 8, 1);
		write_reg(0, udma_pkg::REG_CFG, cfg_word(0, 0, 1, 0, 0));
		write_reg(1, udma_pkg::REG_CFG, cfg_word(0, 1, 1, 0, 1));
		wait_reqs(0, 12, 1);
		wait_reqs(1, 4, 1);
		alt_chk = 1'b0;
		rand_ready = 1'b1;
		write_reg(0, udma_pkg::REG_CFG, cfg_word(0, 0, 1, 0, 0));
		write_reg(1, udma_pkg::REG_CFG, cfg_word(0, 1, 1, 0, 1));
		wait_reqs(0, 24, 1);
		wait_reqs(1, 8, 1);
		rand_ready = 1'b0;
		check_val("requests ch0", 24, req_cnt[0]);
		check_val("requests ch1", 8, req_cnt[1]);
		check_val("ch_event_o pulses", 32'h0002_0002, {ev_cnt[1][15:0], ev_cnt[0][15:0]});
		finish_test("two channels");

		clear_counts();
		setup_ch(0, 18'h01003, 24, 0);
		write_reg(0, udma_pkg::REG_CFG, cfg_word(0, 0, 1, 0, 0));
		wait_reqs(0, 2, 0);
		write_reg(0, udma_pkg::REG_CFG, cfg_word(0, 0, 1, 0, 0));
		read_reg(0, udma_pkg::REG_STATUS, rd);
		check_val("STATUS[17:16]", 2'b11, rd[17:16]);
		wait_reqs(0, 48, 1);
		check_val("requests ch0", 48, req_cnt[0]);
		check_val("ch_event_o[0] pulses", 2, ev_cnt[0]);
		finish_test("pending enable");

		$display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* udma_ch_addrgen.sv */
`timescale 1ns/10ps
`default_nettype none

module udma_ch_addrgen (
	input  logic                   clk_i,
	input  logic                   rstn_i,
	input  udma_pkg::l2_addr_t     cfg_startaddr_i,
	input  udma_pkg::trans_size_t  cfg_size_i,
	input  logic                   cfg_continuous_i,
	input  logic                   cfg_en_i,
	input  logic                   cfg_clr_i,
	input  udma_pkg::datasize_t    cfg_datasize_i,
	input  udma_pkg::stream_t      cfg_stream_i,
	input  udma_pkg::stream_id_t   cfg_stream_id_i,
	input  logic                   not_stall_i,
	input  logic                   grant_i,
	output udma_pkg::l2_addr_t     curr_addr_o,
	output udma_pkg::trans_size_t  bytes_left_o,
	output logic [1:0]             curr_bytes_o,
	output logic                   pending_o,
	output logic                   ch_en_o,
	output logic                   event_o,
	output logic                   sot_o,
	output udma_pkg::stream_t      stream_o,
	output udma_pkg::stream_id_t   stream_id_o
);

	udma_pkg::l2_addr_t    r_addr;
	udma_pkg::l2_addr_t    s_addr;
	udma_pkg::trans_size_t r_cnt;
	udma_pkg::trans_size_t s_cnt;
	udma_pkg::stream_t     r_stream;
	udma_pkg::stream_t     s_stream;
	udma_pkg::stream_id_t  r_stream_id;
	udma_pkg::stream_id_t  s_stream_id;
	udma_pkg::trans_size_t s_beat;
	logic                  r_en;
	logic                  s_en;
	logic                  r_pending;
	logic                  s_pending;
	logic                  r_event;
	logic                  s_event;
	logic                  r_sot;
	logic                  s_sot;
	logic                  s_last;
	logic                  s_step;
	logic                  s_ds_ok;

	assign curr_addr_o  = r_addr;
	assign bytes_left_o = r_cnt;
	assign pending_o    = r_pending;
	assign ch_en_o      = r_en;
	assign event_o      = r_event;
	assign sot_o        = r_sot;
	assign stream_o     = r_stream;
	assign stream_id_o  = r_stream_id;

	always_comb begin : proc_beat
		case (cfg_datasize_i)
			udma_pkg::DS_BYTE: s_beat = 16'd1;
			udma_pkg::DS_HALF: s_beat = 16'd2;
			udma_pkg::DS_WORD: s_beat = 16'd4;
			default:           s_beat = 16'd0;
		endcase
	end

	assign s_ds_ok = (cfg_datasize_i != udma_pkg::DS_RSVD);
	assign s_last  = (r_cnt <= s_beat);
	assign s_step  = r_en && grant_i && not_stall_i;

	// Last beat carries only the bytes that remain.
	assign curr_bytes_o = s_last ? (r_cnt[1:0] - 2'd1) : (s_beat[1:0] - 2'd1);

	always_comb begin : proc_next
		s_addr      = r_addr;
		s_cnt       = r_cnt;
		s_stream    = r_stream;
		s_stream_id = r_stream_id;
		s_en        = r_en;
		s_pending   = r_pending;
		s_event     = 1'b0;
		s_sot       = 1'b0;
		if (cfg_clr_i) begin
			s_addr    = '0;
			s_cnt     = '0;
			s_en      = 1'b0;
			s_pending = 1'b0;
		end else if (cfg_en_i && !r_en) begin
			if (s_ds_ok) begin
				s_addr      = cfg_startaddr_i;
				s_cnt       = cfg_size_i;
				s_stream    = cfg_stream_i;
				s_stream_id = cfg_stream_id_i;
				s_en        = 1'b1;
				s_sot       = 1'b1;
			end
		end else if (s_step) begin
			if (s_last) begin
				s_event = 1'b1;
				if (cfg_continuous_i || r_pending || cfg_en_i) begin
					// Restart from the programmed buffer.
					s_addr      = cfg_startaddr_i;
					s_cnt       = cfg_size_i;
					s_stream    = cfg_stream_i;
					s_stream_id = cfg_stream_id_i;
					s_sot       = 1'b1;
					s_pending   = 1'b0;
				end else begin
					s_addr = '0;
					s_cnt  = '0;
					s_en   = 1'b0;
				end
			end else begin
				s_addr = r_addr + udma_pkg::l2_addr_t'(s_beat);
				s_cnt  = r_cnt - s_beat;
				if (cfg_en_i) begin
					s_pending = 1'b1;
				end
			end
		end else if (cfg_en_i) begin
			s_pending = 1'b1;
		end
	end

	always_ff @(posedge clk_i or negedge rstn_i) begin : proc_regs
		if (!rstn_i) begin
			r_addr      <= '0;
			r_cnt       <= '0;
			r_stream    <= '0;
			r_stream_id <= '0;
			r_en        <= 1'b0;
			r_pending   <= 1'b0;
			r_event     <= 1'b0;
			r_sot       <= 1'b0;
		end else begin
			r_addr      <= s_addr;
			r_cnt       <= s_cnt;
			r_stream    <= s_stream;
			r_stream_id <= s_stream_id;
			r_en        <= s_en;
			r_pending   <= s_pending;
			r_event     <= s_event;
			r_sot       <= s_sot;
		end
	end

	// The arbiter must only pick channels that have work.
	a_grant_needs_en: assert property (
		@(posedge clk_i) disable iff (!rstn_i) grant_i |-> ch_en_o
	);

endmodule

`default_nettype wire

/* udma_ch_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module udma_ch_arbiter #(
	parameter int N_CH = 2,
	localparam int CH_W = (N_CH > 1) ? $clog2(N_CH) : 1
) (
	input  logic            clk_i,
	input  logic            rstn_i,
	input  logic [N_CH-1:0] ch_en_i,
	input  logic            l2_ready_i,
	output logic [N_CH-1:0] grant_o
);

	logic [CH_W-1:0] r_last;
	logic [CH_W-1:0] s_pick;
	logic            s_found;

	// Search starts one past the last granted channel.
	always_comb begin : proc_pick
		int idx;
		s_pick  = '0;
		s_found = 1'b0;
		for (int off = 1; off <= N_CH; off++) begin
			idx = (int'(r_last) + off) % N_CH;
			if (!s_found && ch_en_i[idx]) begin
				s_found = 1'b1;
				s_pick  = CH_W'(idx);
			end
		end
	end

	always_comb begin : proc_grant
		grant_o = '0;
		if (l2_ready_i && s_found) begin
			grant_o[s_pick] = 1'b1;
		end
	end

	always_ff @(posedge clk_i or negedge rstn_i) begin : proc_last
		if (!rstn_i) begin
			r_last <= CH_W'(N_CH - 1);
		end else if (|grant_o) begin
			r_last <= s_pick;
		end
	end

	a_grant_onehot: assert property (
		@(posedge clk_i) disable iff (!rstn_i) $onehot0(grant_o)
	);

endmodule

`default_nettype wire

/* udma_ch_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module udma_ch_regs (
	input  logic                   clk_i,
	input  logic                   rstn_i,
	input  logic                   reg_valid_i,
	input  logic                   reg_we_i,
	input  udma_pkg::reg_off_t     reg_off_i,
	input  udma_pkg::reg_data_t    reg_wdata_i,
	output udma_pkg::reg_data_t    rdata_o,
	input  udma_pkg::trans_size_t  bytes_left_i,
	input  logic                   ch_en_i,
	input  logic                   pending_i,
	output udma_pkg::l2_addr_t     startaddr_o,
	output udma_pkg::trans_size_t  size_o,
	output logic                   continuous_o,
	output udma_pkg::datasize_t    datasize_o,
	output udma_pkg::stream_t      stream_o,
	output udma_pkg::stream_id_t   stream_id_o,
	output logic                   en_o,
	output logic                   clr_o
);

	logic                s_wr;
	logic                s_rd;
	logic                s_wr_cfg;
	udma_pkg::reg_data_t s_rdata;

	assign s_wr     = reg_valid_i && reg_we_i;
	assign s_rd     = reg_valid_i && !reg_we_i;
	assign s_wr_cfg = s_wr && (reg_off_i == udma_pkg::REG_CFG);

	always_ff @(posedge clk_i or negedge rstn_i) begin : proc_cfg
		if (!rstn_i) begin
			startaddr_o  <= '0;
			size_o       <= '0;
			continuous_o <= 1'b0;
			datasize_o   <= udma_pkg::DS_BYTE;
			stream_o     <= '0;
			stream_id_o  <= '0;
			en_o         <= 1'b0;
			clr_o        <= 1'b0;
		end else begin
			// Enable and clear last one cycle.
			en_o  <= s_wr_cfg && reg_wdata_i[udma_pkg::CFG_EN_BIT];
			clr_o <= s_wr_cfg && reg_wdata_i[udma_pkg::CFG_CLR_BIT];
			if (s_wr && (reg_off_i == udma_pkg::REG_SADDR)) begin
				startaddr_o <= reg_wdata_i[$bits(udma_pkg::l2_addr_t)-1:0];
			end
			if (s_wr && (reg_off_i == udma_pkg::REG_SIZE)) begin
				size_o <= reg_wdata_i[$bits(udma_pkg::trans_size_t)-1:0];
			end
			if (s_wr_cfg) begin
				continuous_o <= reg_wdata_i[udma_pkg::CFG_CONT_BIT];
				datasize_o   <= reg_wdata_i[udma_pkg::CFG_DS_LSB +: 2];
				stream_o     <= reg_wdata_i[udma_pkg::CFG_STREAM_LSB +: 2];
				stream_id_o  <= reg_wdata_i[udma_pkg::CFG_SID_LSB +: 3];
			end
		end
	end

	always_comb begin : proc_rmux
		s_rdata = '0;
		case (reg_off_i)
			udma_pkg::REG_SADDR: s_rdata[$bits(udma_pkg::l2_addr_t)-1:0] = startaddr_o;
			udma_pkg::REG_SIZE:  s_rdata[$bits(udma_pkg::trans_size_t)-1:0] = size_o;
			udma_pkg::REG_CFG: begin
				s_rdata[udma_pkg::CFG_CONT_BIT]        = continuous_o;
				s_rdata[udma_pkg::CFG_DS_LSB +: 2]     = datasize_o;
				s_rdata[udma_pkg::CFG_STREAM_LSB +: 2] = stream_o;
				s_rdata[udma_pkg::CFG_SID_LSB +: 3]    = stream_id_o;
			end
			default: begin
				s_rdata[$bits(udma_pkg::trans_size_t)-1:0] = bytes_left_i;
				s_rdata[udma_pkg::STAT_EN_BIT]             = ch_en_i;
				s_rdata[udma_pkg::STAT_PEND_BIT]           = pending_i;
			end
		endcase
	end

	always_ff @(posedge clk_i or negedge rstn_i) begin : proc_rdata
		if (!rstn_i) begin
			rdata_o <= '0;
		end else if (s_rd) begin
			rdata_o <= s_rdata;
		end
	end

endmodule

`default_nettype wire

/* udma_l2_req.sv */
`timescale 1ns/10ps
`default_nettype none

module udma_l2_req #(
	parameter int N_CH = 2,
	localparam int CH_W = (N_CH > 1) ? $clog2(N_CH) : 1
) (
	input  logic                  clk_i,
	input  logic                  rstn_i,
	input  logic [N_CH-1:0]       grant_i,
	input  udma_pkg::l2_addr_t    addr_i [N_CH],
	input  logic [1:0]            curr_bytes_i [N_CH],
	input  udma_pkg::stream_t     stream_i [N_CH],
	input  udma_pkg::stream_id_t  stream_id_i [N_CH],
	output logic                  l2_req_o,
	output udma_pkg::l2_addr_t    l2_addr_o,
	output logic [3:0]            l2_be_o,
	output logic                  l2_we_o,
	output udma_pkg::stream_t     l2_stream_o,
	output udma_pkg::stream_id_t  l2_stream_id_o
);

	logic [CH_W-1:0] s_sel;
	logic [2:0]      s_nbytes;
	logic [4:0]      s_mask;
	logic [3:0]      s_be;

	always_comb begin : proc_sel
		s_sel = '0;
		for (int i = 0; i < N_CH; i++) begin
			if (grant_i[i]) begin
				s_sel = CH_W'(i);
			end
		end
	end

	// Byte lanes from the beat length and the address offset.
	assign s_nbytes = {1'b0, curr_bytes_i[s_sel]} + 3'd1;
	assign s_mask   = (5'd1 << s_nbytes) - 5'd1;
	assign s_be     = s_mask[3:0] << addr_i[s_sel][1:0];

	always_ff @(posedge clk_i or negedge rstn_i) begin : proc_req
		if (!rstn_i) begin
			l2_req_o <= 1'b0;
		end else begin
			l2_req_o <= |grant_i;
		end
	end

	always_ff @(posedge clk_i) begin : proc_payload
		if (|grant_i) begin
			l2_addr_o      <= {addr_i[s_sel][$bits(udma_pkg::l2_addr_t)-1:2], 2'b00};
			l2_be_o        <= s_be;
			// Channel 0 is the RX side and writes into L2.
			l2_we_o        <= (s_sel == '0);
			l2_stream_o    <= stream_i[s_sel];
			l2_stream_id_o <= stream_id_i[s_sel];
		end
	end

	a_req_has_be: assert property (
		@(posedge clk_i) disable iff (!rstn_i) l2_req_o |-> (l2_be_o != 4'b0000)
	);

endmodule

`default_nettype wire

/* udma_pkg.sv */
`default_nettype none

package udma_pkg;

	localparam int REG_DW = 32;

	// L2 byte address without the fixed upper bits.
	typedef logic [17:0] l2_addr_t;
	typedef logic [15:0] trans_size_t;
	typedef logic [1:0] datasize_t;
	typedef logic [1:0] stream_t;
	typedef logic [2:0] stream_id_t;
	typedef logic [1:0] reg_off_t;
	typedef logic [REG_DW-1:0] reg_data_t;

	// Beat width codes.
	localparam datasize_t DS_BYTE = 2'd0;
	localparam datasize_t DS_HALF = 2'd1;
	localparam datasize_t DS_WORD = 2'd2;
	localparam datasize_t DS_RSVD = 2'd3;

	// Register offsets inside one channel.
	localparam reg_off_t REG_SADDR  = 2'd0;
	localparam reg_off_t REG_SIZE   = 2'd1;
	localparam reg_off_t REG_CFG    = 2'd2;
	localparam reg_off_t REG_STATUS = 2'd3;

	// CFG field positions.
	localparam int CFG_CONT_BIT   = 0;
	localparam int CFG_DS_LSB     = 1;
	localparam int CFG_EN_BIT     = 4;
	localparam int CFG_CLR_BIT    = 5;
	localparam int CFG_STREAM_LSB = 6;
	localparam int CFG_SID_LSB    = 8;

	// STATUS flags above the byte count.
	localparam int STAT_EN_BIT   = 16;
	localparam int STAT_PEND_BIT = 17;

endpackage

`default_nettype wire

/* udma_subsys.sv */
`timescale 1ns/10ps
`default_nettype none

module udma_subsys #(
	parameter int N_CH = 2,
	localparam int CH_W = (N_CH > 1) ? $clog2(N_CH) : 1
) (
	input  logic                  clk_i,
	input  logic                  rstn_i,
	input  logic                  reg_valid_i,
	input  logic                  reg_we_i,
	input  logic [CH_W-1:0]       reg_ch_i,
	input  udma_pkg::reg_off_t    reg_off_i,
	input  udma_pkg::reg_data_t   reg_wdata_i,
	output udma_pkg::reg_data_t   reg_rdata_o,
	input  logic                  l2_ready_i,
	output logic                  l2_req_o,
	output udma_pkg::l2_addr_t    l2_addr_o,
	output logic [3:0]            l2_be_o,
	output logic                  l2_we_o,
	output udma_pkg::stream_t     l2_stream_o,
	output udma_pkg::stream_id_t  l2_stream_id_o,
	output logic [N_CH-1:0]       ch_event_o,
	output logic [N_CH-1:0]       ch_sot_o,
	output logic [N_CH-1:0]       ch_active_o
);

	udma_pkg::l2_addr_t    s_startaddr [N_CH];
	udma_pkg::trans_size_t s_size [N_CH];
	udma_pkg::datasize_t   s_datasize [N_CH];
	udma_pkg::stream_t     s_cfg_stream [N_CH];
	udma_pkg::stream_id_t  s_cfg_sid [N_CH];
	udma_pkg::trans_size_t s_bytes_left [N_CH];
	udma_pkg::l2_addr_t    s_curr_addr [N_CH];
	logic [1:0]            s_curr_bytes [N_CH];
	udma_pkg::stream_t     s_stream [N_CH];
	udma_pkg::stream_id_t  s_stream_id [N_CH];
	udma_pkg::reg_data_t   s_rdata [N_CH];
	logic [N_CH-1:0]       s_cont;
	logic [N_CH-1:0]       s_cfg_en;
	logic [N_CH-1:0]       s_cfg_clr;
	logic [N_CH-1:0]       s_pending;
	logic [N_CH-1:0]       s_grant;
	logic [CH_W-1:0]       r_rd_ch;

	for (genvar g = 0; g < N_CH; g++) begin : gen_ch
		udma_ch_regs u_regs (
			.clk_i        (clk_i),
			.rstn_i       (rstn_i),
			.reg_valid_i  (reg_valid_i && (reg_ch_i == CH_W'(g))),
			.reg_we_i     (reg_we_i),
			.reg_off_i    (reg_off_i),
			.reg_wdata_i  (reg_wdata_i),
			.rdata_o      (s_rdata[g]),
			.bytes_left_i (s_bytes_left[g]),
			.ch_en_i      (ch_active_o[g]),
			.pending_i    (s_pending[g]),
			.startaddr_o  (s_startaddr[g]),
			.size_o       (s_size[g]),
			.continuous_o (s_cont[g]),
			.datasize_o   (s_datasize[g]),
			.stream_o     (s_cfg_stream[g]),
			.stream_id_o  (s_cfg_sid[g]),
			.en_o         (s_cfg_en[g]),
			.clr_o        (s_cfg_clr[g])
		);

		udma_ch_addrgen u_addrgen (
			.clk_i            (clk_i),
			.rstn_i           (rstn_i),
			.cfg_startaddr_i  (s_startaddr[g]),
			.cfg_size_i       (s_size[g]),
			.cfg_continuous_i (s_cont[g]),
			.cfg_en_i         (s_cfg_en[g]),
			.cfg_clr_i        (s_cfg_clr[g]),
			.cfg_datasize_i   (s_datasize[g]),
			.cfg_stream_i     (s_cfg_stream[g]),
			.cfg_stream_id_i  (s_cfg_sid[g]),
			.not_stall_i      (l2_ready_i),
			.grant_i          (s_grant[g]),
			.curr_addr_o      (s_curr_addr[g]),
			.bytes_left_o     (s_bytes_left[g]),
			.curr_bytes_o     (s_curr_bytes[g]),
			.pending_o        (s_pending[g]),
			.ch_en_o          (ch_active_o[g]),
			.event_o          (ch_event_o[g]),
			.sot_o            (ch_sot_o[g]),
			.stream_o         (s_stream[g]),
			.stream_id_o      (s_stream_id[g])
		);
	end

	udma_ch_arbiter #(
		.N_CH (N_CH)
	) u_arbiter (
		.clk_i      (clk_i),
		.rstn_i     (rstn_i),
		.ch_en_i    (ch_active_o),
		.l2_ready_i (l2_ready_i),
		.grant_o    (s_grant)
	);

	udma_l2_req #(
		.N_CH (N_CH)
	) u_l2_req (
		.clk_i          (clk_i),
		.rstn_i         (rstn_i),
		.grant_i        (s_grant),
		.addr_i         (s_curr_addr),
		.curr_bytes_i   (s_curr_bytes),
		.stream_i       (s_stream),
		.stream_id_i    (s_stream_id),
		.l2_req_o       (l2_req_o),
		.l2_addr_o      (l2_addr_o),
		.l2_be_o        (l2_be_o),
		.l2_we_o        (l2_we_o),
		.l2_stream_o    (l2_stream_o),
		.l2_stream_id_o (l2_stream_id_o)
	);

	// Read data comes from the channel addressed one cycle earlier.
	always_ff @(posedge clk_i or negedge rstn_i) begin : proc_rd_ch
		if (!rstn_i) begin
			r_rd_ch <= '0;
		end else if (reg_valid_i && !reg_we_i) begin
			r_rd_ch <= reg_ch_i;
		end
	end

	assign reg_rdata_o = s_rdata[r_rd_ch];

endmodule

`default_nettype wire
